// ==== files.f ====
src/sseg_pkg.sv
src/square_animator.sv
src/digit_scanner.sv
src/display_mux.sv
src/fmc_led_top.sv
tests/tb_clock.sv
tests/tb_fmc_led_top.sv

// ==== src/digit_scanner.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Digit scanner
// Refresh prescaler and wrapping digit index
// ~~~~~~~~~~~~~~~~~~~~

module digit_scanner
    import sseg_pkg::*;
#(
    parameter int SCAN_DIV = 65536
)
(
    input  logic                clk,
    input  logic                i_rst,
    output logic [DIGIT_W-1:0]  o_digit_idx
);

    // Prescaler width, enough for SCAN_DIV-1
    localparam int CNT_W = $clog2(SCAN_DIV);

    logic [CNT_W-1:0]  r_scan_cnt;
    logic              w_tick;

    // Wrap on the last count
    assign w_tick = (r_scan_cnt == CNT_W'(SCAN_DIV - 1));

    // Refresh prescaler
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            r_scan_cnt <= '0;
        end
        else if (w_tick)
        begin
            r_scan_cnt <= '0;
        end
        else
        begin
            r_scan_cnt <= r_scan_cnt + 1'b1;
        end
    end

    // Digit index, free running
    // Wraps 3 -> 0 by width
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            o_digit_idx <= '0;
        end
        else if (w_tick)
        begin
            o_digit_idx <= o_digit_idx + 1'b1;
        end
    end

    // Index moves only on prescaler wrap
    a_step_on_tick : assert property (@(posedge clk) disable iff (i_rst)
        (o_digit_idx != $past(o_digit_idx)) |-> $past(w_tick))
        else $error("digit_scanner: index moved without tick");

endmodule

// ==== src/display_mux.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Display multiplexer
// Picks the scanned digit, drives one-hot select,
// blanks one cycle per digit change
// ~~~~~~~~~~~~~~~~~~~~

module display_mux
    import sseg_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic [NUM_DIGITS*8-1:0]  i_digit_n,
    input  logic [DIGIT_W-1:0]       i_digit_idx,
    output logic [7:0]               o_sseg_n,
    output logic [NUM_DIGITS-1:0]    o_ldsel
);

    logic [DIGIT_W-1:0]     r_prev_idx;
    logic                   w_change;
    logic [NUM_DIGITS-1:0]  w_onehot;
    logic [7:0]             w_sel_word;

    // New digit this cycle
    assign w_change = (i_digit_idx != r_prev_idx);

    // Select decode, bit d drives digit d
    assign w_onehot = NUM_DIGITS'(1) << i_digit_idx;

    // Current digit's raw word
    assign w_sel_word = i_digit_n[i_digit_idx*8 +: 8];

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            r_prev_idx <= '0;
            o_ldsel    <= '0;
            o_sseg_n   <= SEG_BLANK;
        end
        else
        begin
            r_prev_idx <= i_digit_idx;
            if (w_change)
            begin
                // Dark for a cycle so old segments never show under the new select
                o_ldsel  <= '0;
                o_sseg_n <= SEG_BLANK;
            end
            else
            begin
                o_ldsel  <= w_onehot;
                o_sseg_n <= w_sel_word;
            end
        end
    end

    // At most one digit selected
    a_sel_onehot0 : assert property (@(posedge clk) disable iff (i_rst) $onehot0(o_ldsel))
        else $error("display_mux: select %b not one-hot", o_ldsel);

    // A new select only ever follows a fully dark cycle
    a_dark_before_select : assert property (@(posedge clk) disable iff (i_rst)
        (o_ldsel != '0 && o_ldsel != $past(o_ldsel))
            |-> ($past(o_ldsel) == '0 && $past(o_sseg_n) == SEG_BLANK))
        else $error("display_mux: select changed with no dark cycle");

endmodule

// ==== src/fmc_led_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// FMC LED top level
// Rotating square on the 4-digit socket,
// VADJ ties and FMC pin mapping
// ~~~~~~~~~~~~~~~~~~~~

// Segment lines on the mezzanine
// a 9N, b 3P, c 9P, d 8N, e CLK0_M2C_N, f 12P, g 8P, dp 5N

// Digit selects on the mezzanine
// L1 2P, L2 2N, L3 4P, L4 CLK1_M2C_N

module fmc_led_top
    import sseg_pkg::*;
#(
    parameter int STEP_DIV = 2**22,
    parameter int SCAN_DIV = 2**16
)
(
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_cw,
    input  logic        i_en,

    // VADJ control
    output logic [1:0]  o_set_vadj,
    output logic        o_vadj_en,

    // Segment pins
    output logic        o_fmc_la_5n,
    output logic        o_fmc_la_8p,
    output logic        o_fmc_la_12p,
    output logic        o_fmc_clk0_m2c_n,
    output logic        o_fmc_la_8n,
    output logic        o_fmc_la_9p,
    output logic        o_fmc_la_3p,
    output logic        o_fmc_la_9n,

    // Select pins
    output logic        o_fmc_la_2p,
    output logic        o_fmc_la_2n,
    output logic        o_fmc_la_4p,
    output logic        o_fmc_clk1_m2c_n
);

    logic [NUM_DIGITS*8-1:0]  w_digit_n;
    logic [DIGIT_W-1:0]       w_digit_idx;
    logic [7:0]               w_sseg_n;
    logic [NUM_DIGITS-1:0]    w_ldsel;

    // VADJ at 1.8 V
    assign o_vadj_en  = 1'b1;
    assign o_set_vadj = 2'b01;

    // Animation position and patterns
    square_animator #(
        .STEP_DIV   (STEP_DIV)
    ) u_square_animator (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_cw       (i_cw),
        .i_en       (i_en),
        .o_digit_n  (w_digit_n)
    );

    // Refresh scan
    digit_scanner #(
        .SCAN_DIV     (SCAN_DIV)
    ) u_digit_scanner (
        .clk          (clk),
        .i_rst        (i_rst),
        .o_digit_idx  (w_digit_idx)
    );

    // Output stage
    display_mux u_display_mux (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_digit_n    (w_digit_n),
        .i_digit_idx  (w_digit_idx),
        .o_sseg_n     (w_sseg_n),
        .o_ldsel      (w_ldsel)
    );

    // Segments dp..a onto their FMC lines
    assign {o_fmc_la_5n, o_fmc_la_8p, o_fmc_la_12p, o_fmc_clk0_m2c_n,
            o_fmc_la_8n, o_fmc_la_9p, o_fmc_la_3p, o_fmc_la_9n} = w_sseg_n;

    // Selects L1..L4, bit 3 first
    assign {o_fmc_la_2p, o_fmc_la_2n, o_fmc_la_4p, o_fmc_clk1_m2c_n} = w_ldsel;

endmodule

// ==== src/square_animator.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Square animator
// Steps a square around the four digits
// and builds the active-low segment patterns
// ~~~~~~~~~~~~~~~~~~~~

module square_animator
    import sseg_pkg::*;
#(
    parameter int STEP_DIV = 4194304
)
(
    input  logic                       clk,
    input  logic                       i_rst,
    input  logic                       i_cw,
    input  logic                       i_en,
    output logic [NUM_DIGITS*8-1:0]    o_digit_n
);

    // Prescaler width, enough for STEP_DIV-1
    localparam int CNT_W = $clog2(STEP_DIV);

    logic [CNT_W-1:0]       r_step_cnt;
    logic                   w_tick;
    logic [POS_W-1:0]       r_pos;
    logic                   w_upper;
    logic [DIGIT_W-1:0]     w_active;
    seg_word_u              w_word [NUM_DIGITS];
    logic [NUM_DIGITS-1:0]  w_lit;

    // Tick on the last count of each step interval
    assign w_tick = (r_step_cnt == CNT_W'(STEP_DIV - 1));

    // Step prescaler
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            r_step_cnt <= '0;
        end
        else if (w_tick)
        begin
            r_step_cnt <= '0;
        end
        else
        begin
            r_step_cnt <= r_step_cnt + 1'b1;
        end
    end

    // Position register, wraps modulo 8 in either direction
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            r_pos <= '0;
        end
        else if (w_tick && i_en)
        begin
            if (i_cw)
            begin
                r_pos <= r_pos + 1'b1;
            end
            else
            begin
                r_pos <= r_pos - 1'b1;
            end
        end
    end

    // First half of the lap runs along the top
    assign w_upper = (r_pos < POS_W'(NUM_POS / 2));

    // Bottom half comes back the other way
    assign w_active = w_upper ? r_pos[DIGIT_W-1:0]
                              : DIGIT_W'(NUM_POS - 1 - int'(r_pos));

    // Pattern builder
    always_comb
    begin
        for (int dig = 0; dig < NUM_DIGITS; dig++)
        begin
            w_word[dig].raw = SEG_BLANK;
            if (dig == int'(w_active))
            begin
                // Low turns a segment on
                if (w_upper)
                begin
                    w_word[dig].seg.a = 1'b0;
                    w_word[dig].seg.b = 1'b0;
                    w_word[dig].seg.f = 1'b0;
                    w_word[dig].seg.g = 1'b0;
                end
                else
                begin
                    w_word[dig].seg.c = 1'b0;
                    w_word[dig].seg.d = 1'b0;
                    w_word[dig].seg.e = 1'b0;
                    w_word[dig].seg.g = 1'b0;
                end
            end
            // Digit d sits in byte d
            o_digit_n[dig*8 +: 8] = w_word[dig].raw;
        end
    end

    // Per-digit lit flags, seen from the packed output
    for (genvar gd = 0; gd < NUM_DIGITS; gd++)
    begin : g_lit
        assign w_lit[gd] = (o_digit_n[gd*8 +: 8] != SEG_BLANK);
    end

    // Square is always on exactly one digit
    a_one_lit : assert property (@(posedge clk) disable iff (i_rst) $onehot(w_lit))
        else $error("square_animator: lit digits %b", w_lit);

endmodule

// ==== src/sseg_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Seven-segment display package
// Socket constants and the segment word type
// ~~~~~~~~~~~~~~~~~~~~

package sseg_pkg;

    // Digits on the LED socket
    localparam int NUM_DIGITS = 4;

    // Width of a digit index
    localparam int DIGIT_W = 2;

    // Positions of the rotating square around the display
    localparam int NUM_POS = 8;

    // Width of a position
    localparam int POS_W = 3;

    // One segment byte, MSB first as on the pin word
    typedef struct packed {
        logic dp;
        logic g;
        logic f;
        logic e;
        logic d;
        logic c;
        logic b;
        logic a;
    } seg_bits_t;

    // Same byte seen as a raw pin word or as named segments
    typedef union packed {
        logic [7:0] raw;
        seg_bits_t  seg;
    } seg_word_u;

    // Active low, so all ones is dark
    localparam logic [7:0] SEG_BLANK = 8'hFF;

endpackage

// ==== tests/tb_clock.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// Free-running clk and a synchronous reset pulse
// ~~~~~~~~~~~~~~~~~~~~

module tb_clock
#(
    parameter int CLK_PERIOD = 8,
    parameter int RST_CYCLES = 8,
    parameter int RST_DLY    = 1
)
(
    output logic  clk,
    output logic  o_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // Clock, first rising edge half a period in
    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2.0) clk = ~clk;
    end

    // Reset over the first edges, released just after an edge
    initial
    begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #(RST_DLY) o_rst = 1'b0;
    end

endmodule

// ==== tests/tb_fmc_led_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the FMC LED top level
// Table of steps and positions checked over full scans
// ~~~~~~~~~~~~~~~~~~~~

module tb_fmc_led_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int STEP_DIV   = 64;
    localparam int SCAN_DIV   = 4;
    localparam int NUM_DIGITS = 4;
    localparam int CLK_PERIOD = 8;
    localparam int DRIVE_DLY  = 1;
    localparam int NUM_ROWS   = 12;
    localparam int MAX_HOLD   = 4;
    localparam int SCAN_LEN   = NUM_DIGITS * SCAN_DIV;
    localparam int WD_MARGIN  = 2000;
    localparam logic [31:0] RAND_SEED = 32'h16b6_1514;

    // Active low so all ones is dark
    localparam logic [7:0] BLANK = 8'hFF;

    // Bit of each segment in the pin word
    localparam int SEG_A = 0;
    localparam int SEG_B = 1;
    localparam int SEG_C = 2;
    localparam int SEG_D = 3;
    localparam int SEG_E = 4;
    localparam int SEG_F = 5;
    localparam int SEG_G = 6;

    logic        clk;
    logic        rst;
    logic        cw;
    logic        en;
    logic [1:0]  set_vadj;
    logic        vadj_en;
    logic        la_5n, la_8p, la_12p, clk0_m2c_n;
    logic        la_8n, la_9p, la_3p, la_9n;
    logic        la_2p, la_2n, la_4p, clk1_m2c_n;
    logic [7:0]  pin_seg;
    logic [3:0]  pin_sel;

    // Stimulus table where a steps value of 0 means a random hold
    bit          tbl_cw    [NUM_ROWS];
    bit          tbl_en    [NUM_ROWS];
    int          tbl_steps [NUM_ROWS];
    int          tbl_pos   [NUM_ROWS];

    int          err_cnt   = 0;
    int          chk_cnt   = 0;
    int          test_cnt  = 0;
    int          test_fail = 0;
    int          cur_edge  = 0;
    bit          table_ready = 1'b0;
    bit          mon_on      = 1'b0;

    tb_clock #(
        .CLK_PERIOD  (CLK_PERIOD),
        .RST_CYCLES  (8),
        .RST_DLY     (DRIVE_DLY)
    ) u_clock (
        .clk    (clk),
        .o_rst  (rst)
    );

    fmc_led_top #(
        .STEP_DIV  (STEP_DIV),
        .SCAN_DIV  (SCAN_DIV)
    ) uut (
        .clk               (clk),
        .i_rst             (rst),
        .i_cw              (cw),
        .i_en              (en),
        .o_set_vadj        (set_vadj),
        .o_vadj_en         (vadj_en),
        .o_fmc_la_5n       (la_5n),
        .o_fmc_la_8p       (la_8p),
        .o_fmc_la_12p      (la_12p),
        .o_fmc_clk0_m2c_n  (clk0_m2c_n),
        .o_fmc_la_8n       (la_8n),
        .o_fmc_la_9p       (la_9p),
        .o_fmc_la_3p       (la_3p),
        .o_fmc_la_9n       (la_9n),
        .o_fmc_la_2p       (la_2p),
        .o_fmc_la_2n       (la_2n),
        .o_fmc_la_4p       (la_4p),
        .o_fmc_clk1_m2c_n  (clk1_m2c_n)
    );

    // Pin words back together as dp..a and L1..L4
    assign pin_seg = {la_5n, la_8p, la_12p, clk0_m2c_n, la_8n, la_9p, la_3p, la_9n};
    assign pin_sel = {la_2p, la_2n, la_4p, clk1_m2c_n};

    // Expected word of one digit at one position
    function automatic logic [7:0] model_pattern(input int pos, input int dig);
        logic [7:0] word;
        int         lit_dig;
        word = BLANK;
        // Top run goes left to right and the bottom run comes back
        if (pos < NUM_DIGITS)
            lit_dig = pos;
        else
            lit_dig = 2 * NUM_DIGITS - 1 - pos;
        if (dig == lit_dig)
        begin
            word[SEG_G] = 1'b0;
            if (pos < NUM_DIGITS)
            begin
                word[SEG_A] = 1'b0;
                word[SEG_B] = 1'b0;
                word[SEG_F] = 1'b0;
            end
            else
            begin
                word[SEG_C] = 1'b0;
                word[SEG_D] = 1'b0;
                word[SEG_E] = 1'b0;
            end
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        chk_cnt++;
        assert (got === exp)
        else
        begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic put_row(input int idx, input bit c, input bit e,
                           input int s, input int p);
        tbl_cw[idx]    = c;
        tbl_en[idx]    = e;
        tbl_steps[idx] = s;
        tbl_pos[idx]   = p;
    endtask

    task automatic load_table();
        // Paused at position 0
        put_row(0, 1'b1, 1'b0, 3, 0);
        // Forward into the bottom run and across 7 -> 0
        put_row(1, 1'b1, 1'b1, 3, 3);
        put_row(2, 1'b1, 1'b1, 2, 5);
        put_row(3, 1'b1, 1'b1, 4, 1);
        put_row(4, 1'b1, 1'b1, 6, 7);
        // Backward with a pause and then across 0 -> 7
        put_row(5, 1'b0, 1'b1, 2, 5);
        put_row(6, 1'b0, 1'b0, 3, 5);
        put_row(7, 1'b0, 1'b1, 6, 7);
        put_row(8, 1'b0, 1'b1, 1, 6);
        // Random holds between the last moves
        put_row(9, 1'b1, 1'b0, 0, 6);
        put_row(10, 1'b1, 1'b1, 2, 0);
        put_row(11, 1'b0, 1'b0, 0, 0);
    endtask

    // Walk to a given edge and drive just after it
    task automatic advance_to(input int target);
        repeat (target - cur_edge) @(posedge clk);
        cur_edge = target;
        #(DRIVE_DLY);
    endtask

    task automatic check_reset_outputs();
        check_value("o_vadj_en", {7'b0, vadj_en}, 8'h01);
        check_value("o_set_vadj", {6'b0, set_vadj}, 8'h01);
        check_value("o_ldsel pins", {4'b0, pin_sel}, 8'h00);
        check_value("o_sseg_n pins", pin_seg, BLANK);
    endtask

    // One full refresh scan compared digit by digit
    task automatic scan_and_compare(input int pos);
        int digit_cycles [NUM_DIGITS];
        int blank_cycles;
        int dig;
        for (int d = 0; d < NUM_DIGITS; d++)
            digit_cycles[d] = 0;
        blank_cycles = 0;
        repeat (SCAN_LEN)
        begin
            @(posedge clk);
            cur_edge++;
            // Sample mid-cycle
            #(CLK_PERIOD / 2);
            if (pin_sel == 4'b0000)
            begin
                blank_cycles++;
                check_value("o_sseg_n while deselected", pin_seg, BLANK);
            end
            else
            begin
                dig = -1;
                for (int d = 0; d < NUM_DIGITS; d++)
                    if (pin_sel == 4'(1 << d))
                        dig = d;
                chk_cnt++;
                assert (dig >= 0)
                else
                begin
                    $display("Select pins %b light more than one digit at %0t", pin_sel, $time);
                    err_cnt++;
                end
                if (dig >= 0)
                begin
                    digit_cycles[dig]++;
                    check_value($sformatf("o_sseg_n digit %0d", dig), pin_seg,
                                model_pattern(pos, dig));
                end
            end
        end
        // Each index holds SCAN_DIV cycles with one of them dark
        for (int d = 0; d < NUM_DIGITS; d++)
            check_value($sformatf("o_ldsel cycles on digit %0d", d),
                        8'(digit_cycles[d]), 8'(SCAN_DIV - 1));
        check_value("o_ldsel blank cycles", 8'(blank_cycles), 8'(NUM_DIGITS));
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before)
            $display("PASS  %s", name);
        else
        begin
            test_fail++;
            $display("FAIL  %s (%0d errors)", name, err_cnt - errs_before);
        end
    endtask

    // Select rules on every cycle after reset
    initial
    begin : select_monitor
        logic [3:0] prev_sel;
        logic [7:0] prev_seg;
        prev_sel = 4'b0000;
        prev_seg = BLANK;
        wait (mon_on);
        forever
        begin
            @(negedge clk);
            chk_cnt++;
            assert ($onehot0(pin_sel))
            else
            begin
                $display("Select pins %b light more than one digit at %0t", pin_sel, $time);
                err_cnt++;
            end
            // No jump from one digit straight to another
            if (pin_sel != 4'b0000 && prev_sel != 4'b0000)
            begin
                chk_cnt++;
                assert (pin_sel == prev_sel)
                else
                begin
                    $display("Select moved from %b to %b with no dark cycle at %0t",
                             prev_sel, pin_sel, $time);
                    err_cnt++;
                end
            end
            // Dark cycle has the segments off too
            if (pin_sel != 4'b0000 && prev_sel == 4'b0000)
                check_value("o_sseg_n before new digit", prev_seg, BLANK);
            prev_sel = pin_sel;
            prev_seg = pin_seg;
        end
    end

    // Bound from the table length
    initial
    begin : watchdog
        int total;
        wait (table_ready);
        total = NUM_ROWS + 4;
        for (int r = 0; r < NUM_ROWS; r++)
            total += tbl_steps[r];
        #(total * STEP_DIV * CLK_PERIOD + WD_MARGIN);
        $display("Watchdog expired after %0d step intervals, run stopped", total);
        $display("sim failed");
        $finish;
    end

    initial
    begin : main_flow
        int seed_val;
        int errs_before;
        int row_start;
        cw = 1'b0;
        en = 1'b0;
        seed_val = $urandom(RAND_SEED);
        load_table();
        for (int r = 0; r < NUM_ROWS; r++)
            if (tbl_steps[r] == 0)
                tbl_steps[r] = 1 + ($urandom % MAX_HOLD);
        table_ready = 1'b1;

        // Reset state up to the cycle before edge 1
        errs_before = err_cnt;
        // First rising edge loads the reset values
        @(posedge clk);
        @(negedge clk);
        while (rst)
        begin
            check_reset_outputs();
            @(negedge clk);
        end
        check_reset_outputs();
        report_test("reset state and VADJ pins", errs_before);
        mon_on = 1'b1;

        // First interval idle so rows start on a step boundary
        advance_to(STEP_DIV);
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            errs_before = err_cnt;
            row_start   = cur_edge;
            cw = tbl_cw[r];
            en = tbl_en[r];
            advance_to(row_start + tbl_steps[r] * STEP_DIV);
            // Freeze for the check interval
            en = 1'b0;
            advance_to(cur_edge + STEP_DIV / 2);
            scan_and_compare(tbl_pos[r]);
            advance_to(row_start + (tbl_steps[r] + 1) * STEP_DIV);
            report_test($sformatf("row %0d cw=%0d en=%0d steps=%0d pos=%0d", r, tbl_cw[r],
                                  tbl_en[r], tbl_steps[r], tbl_pos[r]), errs_before);
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, test_fail, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
